//--- hdl/vuad_pkg.sv
// UA geometry package

package vuad_pkg;

   ////////////////////
   // Cache geometry
   ////////////////////

   // Ways per set
   localparam int NUM_WAYS = 12;

   // Set index width and set count
   localparam int SET_BITS = 6;
   localparam int NUM_SETS = 64;

   ////////////////////
   // Array row layout
   ////////////////////

   // Two parity bits on top of two way vectors
   localparam int ROW_BITS = 26;

   // Even parity over the used field
   localparam int USED_PAR_POS = 25;

   // Even parity over the alloc field
   localparam int ALLOC_PAR_POS = 24;

   // Used field at 23..12
   localparam int USED_LSB = 12;

   // Alloc field at 11..0
   localparam int ALLOC_LSB = 0;

endpackage

//--- hdl/vuad_ua_array.sv
// UA row array
`timescale 1ns/1ps

module vuad_ua_array
   import vuad_pkg::*;
(
   input  logic                rclk,
   input  logic                arst_n,
   input  logic [SET_BITS-1:0] rd_set,
   input  logic                wr_en,
   input  logic [SET_BITS-1:0] wr_set,
   input  logic [ROW_BITS-1:0] wr_data,
   output logic [ROW_BITS-1:0] rd_data
);

   // One row per set
   logic [ROW_BITS-1:0] mem [NUM_SETS];

   // Write register stage
   logic                wr_en_c5;
   logic [SET_BITS-1:0] wr_set_c5;
   logic [ROW_BITS-1:0] wr_data_c5;

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         wr_en_c5 <= 1'b0;
      end else begin
         wr_en_c5 <= wr_en;
      end
   end

   always_ff @(posedge rclk) begin
      wr_set_c5  <= wr_set;
      wr_data_c5 <= wr_data;
   end

   // Commit at end of C5
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_SETS; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_en_c5) begin
         mem[wr_set_c5] <= wr_data_c5;
      end
   end

   // Read is flow-through
   assign rd_data = mem[rd_set];

endmodule

//--- hdl/vuad_bypass_ctl.sv
// UA bypass control
`timescale 1ns/1ps

module vuad_bypass_ctl
   import vuad_pkg::*;
(
   input  logic                rclk,
   input  logic                arst_n,
   input  logic                req_vld_c1,
   input  logic [SET_BITS-1:0] req_set_c1,
   input  logic                diag_wr_c1,
   // Bypass selects to the datapath
   output logic                vuad_sel_rd,
   output logic                vuad_sel_c2,
   output logic                vuad_sel_c3,
   output logic                vuad_sel_c4,
   output logic                vuad_sel_c2_d1,
   // Write control at C4
   output logic                diag_wr_c4,
   output logic                array_wr_en_c4,
   output logic [SET_BITS-1:0] array_wr_set_c4
);

   // Stage valids
   logic                vld_c2, vld_c3, vld_c4, vld_c5;
   // Diag write rides along with its request
   logic                dwr_c2, dwr_c3;
   // Stage set indexes
   logic [SET_BITS-1:0] set_c2, set_c3, set_c4, set_c5;
   // Same-set matches against C1
   logic                hit_c2, hit_c3, hit_c4, hit_c5;

   ////////////////////
   // Stage pipe
   ////////////////////

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         vld_c2         <= 1'b0;
         vld_c3         <= 1'b0;
         vld_c4         <= 1'b0;
         vld_c5         <= 1'b0;
         dwr_c2         <= 1'b0;
         dwr_c3         <= 1'b0;
         diag_wr_c4     <= 1'b0;
         vuad_sel_c2_d1 <= 1'b0;
      end else begin
         vld_c2         <= req_vld_c1;
         vld_c3         <= vld_c2;
         vld_c4         <= vld_c3;
         vld_c5         <= vld_c4;
         // A diag write is a request too
         dwr_c2         <= req_vld_c1 & diag_wr_c1;
         dwr_c3         <= dwr_c2;
         diag_wr_c4     <= dwr_c3;
         // C2 match turns into a C3 fixup next cycle
         vuad_sel_c2_d1 <= vuad_sel_c2;
      end
   end

   always_ff @(posedge rclk) begin
      set_c2 <= req_set_c1;
      set_c3 <= set_c2;
      set_c4 <= set_c3;
      set_c5 <= set_c4;
   end

   ////////////////////
   // Bypass selects
   ////////////////////

   assign hit_c2 = req_vld_c1 & vld_c2 & (set_c2 == req_set_c1);
   assign hit_c3 = req_vld_c1 & vld_c3 & (set_c3 == req_set_c1);
   assign hit_c4 = req_vld_c1 & vld_c4 & (set_c4 == req_set_c1);
   assign hit_c5 = req_vld_c1 & vld_c5 & (set_c5 == req_set_c1);

   // Younger stage has priority
   assign vuad_sel_c2 = hit_c2;
   assign vuad_sel_c3 = ~hit_c2 & hit_c3;
   assign vuad_sel_c4 = ~hit_c2 & ~hit_c3 & hit_c4;

   // No match anywhere reads the array
   // C5 source is implied by all selects low
   assign vuad_sel_rd = ~(hit_c2 | hit_c3 | hit_c4 | hit_c5);

   // Write back every request at C4
   assign array_wr_en_c4  = vld_c4;
   assign array_wr_set_c4 = set_c4;

endmodule

//--- hdl/vuad_ua_dp.sv
// UA datapath
`timescale 1ns/1ps

module vuad_ua_dp
   import vuad_pkg::*;
(
   input  logic                rclk,
   input  logic                arst_n,
   // Array read and bypass selects
   input  logic [ROW_BITS-1:0] array_rd_data_c1,
   input  logic                vuad_sel_rd,
   input  logic                vuad_sel_c2,
   input  logic                vuad_sel_c3,
   input  logic                vuad_sel_c4,
   input  logic                vuad_sel_c2_d1,
   // Diagnostic access
   input  logic                diag_rd_c1,
   input  logic                diag_wr_c4,
   input  logic [ROW_BITS-1:0] diag_wr_data_c4,
   // C3 results from the tag pipeline
   input  logic [NUM_WAYS-1:0] hit_wayvld_c3,
   input  logic [NUM_WAYS-1:0] fill_way_c3,
   input  logic [NUM_WAYS-1:0] lru_way_sel_c3,
   input  logic                vuad_evict_c3,
   input  logic                wr64_inst_c3,
   input  logic                alloc_set_cond_c3,
   input  logic                alloc_rst_cond_c3,
   input  logic                fbctl_vuad_bypassed_c3,
   // Array write and C2 results
   output logic [ROW_BITS-1:0] array_wr_data_c4,
   output logic [NUM_WAYS-1:0] vuad_dp_used_c2,
   output logic [NUM_WAYS-1:0] vuad_dp_alloc_c2,
   output logic [ROW_BITS-1:0] diag_rd_ua_out,
   output logic                used_par_err_c2,
   output logic                alloc_par_err_c2
);

   logic [NUM_WAYS-1:0] used_c1, used_byp_c1, used_c2, used_c2_in, used_c3, used_c3_upd;
   logic [NUM_WAYS-1:0] alloc_c1, alloc_byp_c1, alloc_c2, alloc_c2_in, alloc_c3;
   logic [NUM_WAYS-1:0] alloc_c3_upd;
   logic                all_ways_busy_c3;
   logic [ROW_BITS-1:0] row_c3;
   logic [ROW_BITS-1:0] row_c4;
   logic [ROW_BITS-1:0] row_c5;
   logic [ROW_BITS-1:0] rd_row_c2;
   logic                diag_rd_c2;

   ////////////////////
   // C1 bypass
   ////////////////////

   // Youngest older match wins
   // C5 is taken when no other source is selected
   always_comb begin
      if (vuad_sel_c2) begin
         used_byp_c1  = used_c2_in;
         alloc_byp_c1 = alloc_c2_in;
      end else if (vuad_sel_c3) begin
         used_byp_c1  = used_c3_upd;
         alloc_byp_c1 = alloc_c3_upd;
      end else if (vuad_sel_c4) begin
         used_byp_c1  = array_wr_data_c4[USED_LSB +: NUM_WAYS];
         alloc_byp_c1 = array_wr_data_c4[ALLOC_LSB +: NUM_WAYS];
      end else begin
         used_byp_c1  = row_c5[USED_LSB +: NUM_WAYS];
         alloc_byp_c1 = row_c5[ALLOC_LSB +: NUM_WAYS];
      end
   end

   // Array or in-flight value
   assign used_c1  = vuad_sel_rd ? array_rd_data_c1[USED_LSB +: NUM_WAYS] : used_byp_c1;
   assign alloc_c1 = vuad_sel_rd ? array_rd_data_c1[ALLOC_LSB +: NUM_WAYS] : alloc_byp_c1;

   ////////////////////
   // C2 and C3 fields
   ////////////////////

   always_ff @(posedge rclk) begin
      used_c2  <= used_c1;
      alloc_c2 <= alloc_c1;
      used_c3  <= used_c2_in;
      alloc_c3 <= alloc_c2_in;
   end

   // Older request was at C2 last cycle
   // its C3 result is now the fresh copy
   assign used_c2_in  = vuad_sel_c2_d1 ? used_c3_upd : used_c2;
   assign alloc_c2_in = vuad_sel_c2_d1 ? alloc_c3_upd : alloc_c2;

   assign vuad_dp_used_c2  = used_c2_in;
   assign vuad_dp_alloc_c2 = alloc_c2_in;

   ////////////////////
   // C3 update
   ////////////////////

   // Every way used or allocated
   assign all_ways_busy_c3 = &(used_c3 | alloc_c3);

   // Set on fill and hit, cleared on evict, store hit, or a full set
   assign used_c3_upd = (used_c3 | fill_way_c3 | hit_wayvld_c3) &
                        ~(({NUM_WAYS{vuad_evict_c3}} & lru_way_sel_c3) |
                          ({NUM_WAYS{wr64_inst_c3}} & hit_wayvld_c3) |
                          {NUM_WAYS{all_ways_busy_c3}});

   // Set on hit condition or evict, cleared on reset condition or bypassed fill
   assign alloc_c3_upd = (alloc_c3 |
                          ({NUM_WAYS{alloc_set_cond_c3}} & hit_wayvld_c3) |
                          ({NUM_WAYS{vuad_evict_c3}} & lru_way_sel_c3)) &
                         ~(({NUM_WAYS{alloc_rst_cond_c3}} & hit_wayvld_c3) |
                           ({NUM_WAYS{fbctl_vuad_bypassed_c3}} & fill_way_c3));

   // Row with fresh parity
   always_comb begin
      row_c3                          = '0;
      row_c3[USED_LSB +: NUM_WAYS]    = used_c3_upd;
      row_c3[ALLOC_LSB +: NUM_WAYS]   = alloc_c3_upd;
      row_c3[USED_PAR_POS]            = ^used_c3_upd;
      row_c3[ALLOC_PAR_POS]           = ^alloc_c3_upd;
   end

   ////////////////////
   // C4 and C5 write data
   ////////////////////

   always_ff @(posedge rclk) begin
      row_c4 <= row_c3;
      row_c5 <= array_wr_data_c4;
   end

   // Diagnostic row goes in raw, parity included
   assign array_wr_data_c4 = diag_wr_c4 ? diag_wr_data_c4 : row_c4;

   ////////////////////
   // Raw read and parity check
   ////////////////////

   always_ff @(posedge rclk) begin
      rd_row_c2 <= array_rd_data_c1;
   end

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         diag_rd_c2 <= 1'b0;
      end else begin
         diag_rd_c2 <= diag_rd_c1;
      end
   end

   // Diag bus only carries the row on a diag read
   assign diag_rd_ua_out = diag_rd_c2 ? rd_row_c2 : '0;

   // Recomputed parity against stored bit
   assign used_par_err_c2  = (^rd_row_c2[USED_LSB +: NUM_WAYS]) ^ rd_row_c2[USED_PAR_POS];
   assign alloc_par_err_c2 = (^rd_row_c2[ALLOC_LSB +: NUM_WAYS]) ^ rd_row_c2[ALLOC_PAR_POS];

endmodule

//--- hdl/vuad_top.sv
// UA pipeline top
`timescale 1ns/1ps

module vuad_top
   import vuad_pkg::*;
(
   input  logic                rclk,
   input  logic                arst_n,
   // C1 request
   input  logic                req_vld_c1,
   input  logic [SET_BITS-1:0] req_set_c1,
   input  logic                diag_rd_c1,
   input  logic                diag_wr_c1,
   // C3 tag pipeline results
   input  logic [NUM_WAYS-1:0] hit_wayvld_c3,
   input  logic [NUM_WAYS-1:0] fill_way_c3,
   input  logic [NUM_WAYS-1:0] lru_way_sel_c3,
   input  logic                vuad_evict_c3,
   input  logic                wr64_inst_c3,
   input  logic                alloc_set_cond_c3,
   input  logic                alloc_rst_cond_c3,
   input  logic                fbctl_vuad_bypassed_c3,
   // C4 diag row
   input  logic [ROW_BITS-1:0] diag_wr_data_c4,
   // C2 results
   output logic [NUM_WAYS-1:0] vuad_dp_used_c2,
   output logic [NUM_WAYS-1:0] vuad_dp_alloc_c2,
   output logic [ROW_BITS-1:0] diag_rd_ua_out,
   output logic                used_par_err_c2,
   output logic                alloc_par_err_c2
);

   logic                vuad_sel_rd, vuad_sel_c2, vuad_sel_c3, vuad_sel_c4;
   logic                vuad_sel_c2_d1;
   logic                diag_wr_c4;
   logic                array_wr_en_c4;
   logic [SET_BITS-1:0] array_wr_set_c4;
   logic [ROW_BITS-1:0] array_rd_data_c1;
   logic [ROW_BITS-1:0] array_wr_data_c4;

   vuad_bypass_ctl vuad_bypass_ctl_i (
      .rclk, .arst_n, .req_vld_c1, .req_set_c1, .diag_wr_c1,
      .vuad_sel_rd, .vuad_sel_c2, .vuad_sel_c3, .vuad_sel_c4, .vuad_sel_c2_d1,
      .diag_wr_c4, .array_wr_en_c4, .array_wr_set_c4
   );

   vuad_ua_dp vuad_ua_dp_i (
      .rclk, .arst_n, .array_rd_data_c1,
      .vuad_sel_rd, .vuad_sel_c2, .vuad_sel_c3, .vuad_sel_c4, .vuad_sel_c2_d1,
      .diag_rd_c1, .diag_wr_c4, .diag_wr_data_c4,
      .hit_wayvld_c3, .fill_way_c3, .lru_way_sel_c3, .vuad_evict_c3, .wr64_inst_c3,
      .alloc_set_cond_c3, .alloc_rst_cond_c3, .fbctl_vuad_bypassed_c3,
      .array_wr_data_c4, .vuad_dp_used_c2, .vuad_dp_alloc_c2,
      .diag_rd_ua_out, .used_par_err_c2, .alloc_par_err_c2
   );

   // Read at C1, write registered at C4
   vuad_ua_array vuad_ua_array_i (
      .rclk,
      .arst_n,
      .rd_set  (req_set_c1),
      .wr_en   (array_wr_en_c4),
      .wr_set  (array_wr_set_c4),
      .wr_data (array_wr_data_c4),
      .rd_data (array_rd_data_c1)
   );

endmodule

//--- sim/vuad_sva.sv
// UA control assertions
`timescale 1ns/1ps

module vuad_sva (
   input logic rclk,
   input logic arst_n,
   input logic req_vld_c1,
   input logic vuad_sel_rd,
   input logic vuad_sel_c2,
   input logic vuad_sel_c3,
   input logic vuad_sel_c4,
   input logic array_wr_en_c4,
   input logic vld_c2,
   input logic vld_c3,
   input logic vld_c4,
   input logic vld_c5
);

   // At most one bypass source, C5 when all are low
   sel_onehot: assert property (@(posedge rclk) disable iff (!arst_n)
      $onehot0({vuad_sel_rd, vuad_sel_c2, vuad_sel_c3, vuad_sel_c4}))
      else $error("bypass selects are not one-hot");

   // Write-back three cycles after the request
   wr_en_latency: assert property (@(posedge rclk) disable iff (!arst_n)
      array_wr_en_c4 == $past(req_vld_c1, 3))
      else $error("array write enable does not follow the request by three cycles");

   // Pipe empty while in reset
   reset_idle: assert property (@(posedge rclk)
      !arst_n |-> !(vld_c2 | vld_c3 | vld_c4 | vld_c5 | array_wr_en_c4))
      else $error("stage valid seen during reset");

endmodule

bind vuad_bypass_ctl vuad_sva vuad_sva_i (
   .rclk, .arst_n, .req_vld_c1,
   .vuad_sel_rd, .vuad_sel_c2, .vuad_sel_c3, .vuad_sel_c4,
   .array_wr_en_c4, .vld_c2, .vld_c3, .vld_c4, .vld_c5
);

//--- sim/vuad_tb.sv
// UA pipeline testbench
`timescale 1ns/1ps

module vuad_tb
   import vuad_pkg::*;
();

   logic                rclk, arst_n;
   logic                req_vld_c1, diag_rd_c1, diag_wr_c1;
   logic [SET_BITS-1:0] req_set_c1;
   logic [NUM_WAYS-1:0] hit_wayvld_c3, fill_way_c3, lru_way_sel_c3;
   logic                vuad_evict_c3, wr64_inst_c3, alloc_set_cond_c3;
   logic                alloc_rst_cond_c3, fbctl_vuad_bypassed_c3;
   logic [ROW_BITS-1:0] diag_wr_data_c4;
   logic [NUM_WAYS-1:0] vuad_dp_used_c2, vuad_dp_alloc_c2;
   logic [ROW_BITS-1:0] diag_rd_ua_out;
   logic                used_par_err_c2, alloc_par_err_c2;

   // Stimulus lines
   string               ln_name[$];
   int                  ln_op[$], ln_gap[$];
   logic [SET_BITS-1:0] ln_set[$];
   logic [NUM_WAYS-1:0] ln_hit[$], ln_fill[$], ln_lru[$], ln_eu[$], ln_ea[$];
   logic [4:0]          ln_flags[$];
   logic [ROW_BITS-1:0] ln_diag[$], ln_ed[$];
   // Model row seen by each request at C1
   logic [ROW_BITS-1:0] ln_mrow[$];
   // Sequential reference rows
   logic [ROW_BITS-1:0] model_row [NUM_SETS];

   int c1_idx, c2_idx, c3_idx, c4_idx;
   int err_count, wd_cycles;

   vuad_top vuad_top_i (.*);

   initial begin
      rclk = 1'b0;
      forever #50 rclk = ~rclk;
   end

   ////////////////////
   // Reference model
   ////////////////////

   function automatic logic [ROW_BITS-1:0] next_row(input logic [ROW_BITS-1:0] row,
                                                     input int i);
      logic [NUM_WAYS-1:0] u, a, nu, na;
      logic [ROW_BITS-1:0] r;
      u = row[USED_LSB +: NUM_WAYS];
      a = row[ALLOC_LSB +: NUM_WAYS];
      // Flag bits evict, wr64, alloc set, alloc reset, fill bypassed
      nu = u | ln_fill[i] | ln_hit[i];
      if (ln_flags[i][4]) nu = nu & ~ln_lru[i];
      if (ln_flags[i][3]) nu = nu & ~ln_hit[i];
      if (&(u | a)) nu = '0;
      na = a;
      if (ln_flags[i][2]) na = na | ln_hit[i];
      if (ln_flags[i][4]) na = na | ln_lru[i];
      if (ln_flags[i][1]) na = na & ~ln_hit[i];
      if (ln_flags[i][0]) na = na & ~ln_fill[i];
      r = '0;
      r[USED_LSB +: NUM_WAYS]  = nu;
      r[ALLOC_LSB +: NUM_WAYS] = na;
      r[USED_PAR_POS]          = ^nu;
      r[ALLOC_PAR_POS]         = ^na;
      // Diag write stores the raw row
      if (ln_op[i] == 2) r = ln_diag[i];
      return r;
   endfunction

   task automatic report_mismatch(input string name, input string what,
                                  input logic [ROW_BITS-1:0] exp, act);
      $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
      err_count++;
   endtask

   // Record what the request sees, then advance its set
   task automatic issue_line(input int i);
      logic [ROW_BITS-1:0] row;
      row = model_row[ln_set[i]];
      ln_mrow[i] = row;
      if (ln_eu[i] !== row[USED_LSB +: NUM_WAYS])
         report_mismatch(ln_name[i], "file used", ROW_BITS'(row[USED_LSB +: NUM_WAYS]),
                         ROW_BITS'(ln_eu[i]));
      if (ln_ea[i] !== row[ALLOC_LSB +: NUM_WAYS])
         report_mismatch(ln_name[i], "file alloc", ROW_BITS'(row[ALLOC_LSB +: NUM_WAYS]),
                         ROW_BITS'(ln_ea[i]));
      if (ln_op[i] == 1 && ln_ed[i] !== row)
         report_mismatch(ln_name[i], "file diag", row, ln_ed[i]);
      model_row[ln_set[i]] = next_row(row, i);
   endtask

   task automatic check_c2(input int i);
      logic [ROW_BITS-1:0] row;
      logic                upe, ape;
      row = ln_mrow[i];
      upe = (^row[USED_LSB +: NUM_WAYS]) ^ row[USED_PAR_POS];
      ape = (^row[ALLOC_LSB +: NUM_WAYS]) ^ row[ALLOC_PAR_POS];
      if (vuad_dp_used_c2 !== row[USED_LSB +: NUM_WAYS])
         report_mismatch(ln_name[i], "used", ROW_BITS'(row[USED_LSB +: NUM_WAYS]),
                         ROW_BITS'(vuad_dp_used_c2));
      if (vuad_dp_alloc_c2 !== row[ALLOC_LSB +: NUM_WAYS])
         report_mismatch(ln_name[i], "alloc", ROW_BITS'(row[ALLOC_LSB +: NUM_WAYS]),
                         ROW_BITS'(vuad_dp_alloc_c2));
      if (ln_op[i] == 1) begin
         if (diag_rd_ua_out !== row)
            report_mismatch(ln_name[i], "diag row", row, diag_rd_ua_out);
         if (used_par_err_c2 !== upe)
            report_mismatch(ln_name[i], "used parity error", ROW_BITS'(upe),
                            ROW_BITS'(used_par_err_c2));
         if (alloc_par_err_c2 !== ape)
            report_mismatch(ln_name[i], "alloc parity error", ROW_BITS'(ape),
                            ROW_BITS'(alloc_par_err_c2));
      end
   endtask

   ////////////////////
   // Cycle driver
   ////////////////////

   // Shift the stage view, drive C1, C3 and C4, then check C2
   task automatic tick(input int new_idx);
      @(negedge rclk);
      c4_idx = c3_idx;
      c3_idx = c2_idx;
      c2_idx = c1_idx;
      c1_idx = new_idx;
      if (new_idx >= 0) issue_line(new_idx);
      req_vld_c1 = (c1_idx >= 0);
      req_set_c1 = (c1_idx >= 0) ? ln_set[c1_idx] : '0;
      diag_rd_c1 = (c1_idx >= 0) && (ln_op[c1_idx] == 1);
      diag_wr_c1 = (c1_idx >= 0) && (ln_op[c1_idx] == 2);
      hit_wayvld_c3          = (c3_idx >= 0) ? ln_hit[c3_idx] : '0;
      fill_way_c3            = (c3_idx >= 0) ? ln_fill[c3_idx] : '0;
      lru_way_sel_c3         = (c3_idx >= 0) ? ln_lru[c3_idx] : '0;
      vuad_evict_c3          = (c3_idx >= 0) && ln_flags[c3_idx][4];
      wr64_inst_c3           = (c3_idx >= 0) && ln_flags[c3_idx][3];
      alloc_set_cond_c3      = (c3_idx >= 0) && ln_flags[c3_idx][2];
      alloc_rst_cond_c3      = (c3_idx >= 0) && ln_flags[c3_idx][1];
      fbctl_vuad_bypassed_c3 = (c3_idx >= 0) && ln_flags[c3_idx][0];
      diag_wr_data_c4        = (c4_idx >= 0) ? ln_diag[c4_idx] : '0;
      // C2 outputs settle after the C3 inputs change
      #1;
      if (c2_idx >= 0) check_c2(c2_idx);
   endtask

   task automatic load_lines(output bit ok);
      int    fd, code, op, st, hit, fill, lru, ev, w64, as, ar, fb, diag, gap, eu, ea, ed;
      string line, nm;
      ok = 1'b0;
      fd = $fopen("sim/vuad_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file sim/vuad_input.txt");
         return;
      end
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code > 1 && line[0] != "#") begin
            code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h", nm, op,
                           st, hit, fill, lru, ev, w64, as, ar, fb, diag, gap, eu, ea, ed);
            if (code != 16) begin
               $display("malformed stimulus line: %s", line);
               return;
            end
            ln_name.push_back(nm);
            ln_op.push_back(op);
            ln_gap.push_back(gap);
            ln_set.push_back(st[SET_BITS-1:0]);
            ln_hit.push_back(hit[NUM_WAYS-1:0]);
            ln_fill.push_back(fill[NUM_WAYS-1:0]);
            ln_lru.push_back(lru[NUM_WAYS-1:0]);
            ln_flags.push_back({ev[0], w64[0], as[0], ar[0], fb[0]});
            ln_diag.push_back(diag[ROW_BITS-1:0]);
            ln_eu.push_back(eu[NUM_WAYS-1:0]);
            ln_ea.push_back(ea[NUM_WAYS-1:0]);
            ln_ed.push_back(ed[ROW_BITS-1:0]);
            ln_mrow.push_back('0);
         end
      end
      $fclose(fd);
      ok = (ln_name.size() > 0);
      if (!ok) $display("stimulus file holds no request lines");
   endtask

   task automatic run_lines();
      int budget, extra;
      budget = 26;
      foreach (ln_gap[i]) budget += ln_gap[i] + 2;
      wd_cycles = budget * 2;
      foreach (ln_name[i]) begin
         tick(i);
         // Idle padding only where spacing does not matter
         extra = (ln_gap[i] >= 8) ? int'($urandom % 2) : 0;
         repeat (ln_gap[i] + extra) tick(-1);
      end
      // Drain the pipe
      repeat (6) tick(-1);
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      bit ok;
      void'($urandom(32'h21208877));
      arst_n = 1'b0;
      req_vld_c1 = 1'b0;
      req_set_c1 = '0;
      diag_rd_c1 = 1'b0;
      diag_wr_c1 = 1'b0;
      hit_wayvld_c3 = '0;
      fill_way_c3 = '0;
      lru_way_sel_c3 = '0;
      vuad_evict_c3 = 1'b0;
      wr64_inst_c3 = 1'b0;
      alloc_set_cond_c3 = 1'b0;
      alloc_rst_cond_c3 = 1'b0;
      fbctl_vuad_bypassed_c3 = 1'b0;
      diag_wr_data_c4 = '0;
      c1_idx = -1;
      c2_idx = -1;
      c3_idx = -1;
      c4_idx = -1;
      err_count = 0;
      wd_cycles = 0;
      foreach (model_row[s]) model_row[s] = '0;
      repeat (5) @(negedge rclk);
      arst_n = 1'b1;
      load_lines(ok);
      if (!ok) begin
         $display("TEST FAILED");
         $finish;
      end else begin
         run_lines();
         $display("lines %0d, errors %0d", ln_name.size(), err_count);
         if (err_count == 0) begin
            $display("TEST PASSED");
         end else begin
            $display("TEST FAILED");
         end
         $finish;
      end
   end

   // Watchdog sized from the loaded lines
   initial begin
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge rclk);
      $display("watchdog timeout, the run did not finish in %0d cycles", wd_cycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule

//--- compile.f
hdl/vuad_pkg.sv
hdl/vuad_ua_array.sv
hdl/vuad_bypass_ctl.sv
hdl/vuad_ua_dp.sv
hdl/vuad_top.sv
sim/vuad_sva.sv
sim/vuad_tb.sv

//--- Makefile
# Verilator build for the UA pipeline testbench

TOP := vuad_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/vuad_input.txt
# name op(0 req,1 diag rd,2 diag wr) set hit fill lru evict wr64 aset arst fbyp diag gap
# exp_used exp_alloc exp_diag (C2 values before this request's own update)
iso_fill   0 01 000 003 000 0 0 0 0 0 0000000 8 000 000 0000000
iso_hit    0 01 010 000 000 0 0 1 0 0 0000000 8 003 000 0000000
iso_evict  0 01 000 000 001 1 0 0 0 0 0000000 8 013 010 0000000
iso_read   0 01 000 000 000 0 0 0 0 0 0000000 8 012 011 0000000
iso_store  0 01 001 000 000 0 1 0 1 0 0000000 8 012 011 0000000
iso_fbyp   0 01 000 010 000 0 0 0 0 1 0000000 8 012 010 0000000
iso_check  0 01 000 000 000 0 0 0 0 0 0000000 8 012 000 0000000
b2b_d1a    0 02 000 001 000 0 0 0 0 0 0000000 0 000 000 0000000
b2b_d1b    0 02 000 002 000 0 0 0 0 0 0000000 1 001 000 0000000
b2b_d2     0 02 004 000 000 0 0 1 0 0 0000000 2 003 000 0000000
b2b_d3     0 02 000 008 000 0 0 0 0 0 0000000 3 007 004 0000000
b2b_d4     0 02 000 000 001 1 0 0 0 0 0000000 4 00f 004 0000000
b2b_d5     0 02 000 000 000 0 0 0 0 0 0000000 0 00e 005 0000000
b2b_other  0 03 000 001 000 0 0 0 0 0 0000000 0 000 000 0000000
b2b_c3     0 02 010 000 000 0 0 0 0 0 0000000 8 00e 005 0000000
full_fill  0 04 000 0ff 000 0 0 0 0 0 0000000 0 000 000 0000000
full_alloc 0 04 f00 000 000 0 0 1 0 0 0000000 0 0ff 000 0000000
full_clear 0 04 000 000 000 0 0 0 0 0 0000000 0 fff f00 0000000
full_after 0 04 000 000 000 0 0 0 0 0 0000000 8 000 f00 0000000
dw_good    2 05 000 000 000 0 0 0 0 0 00a5003 8 000 000 0000000
dr_good    1 05 000 000 000 0 0 0 0 0 0000000 8 0a5 003 00a5003
dw_par1    2 06 000 000 000 0 0 0 0 0 3007001 8 000 000 0000000
dr_par1    1 06 000 000 000 0 0 0 0 0 0000000 8 007 001 3007001
dw_badu    2 07 000 000 000 0 0 0 0 0 1007001 8 000 000 0000000
dr_badu    1 07 000 000 000 0 0 0 0 0 0000000 8 007 001 1007001
dw_bada    2 08 000 000 000 0 0 0 0 0 2007001 8 000 000 0000000
dr_bada    1 08 000 000 000 0 0 0 0 0 0000000 8 007 001 2007001
sweep_s1   1 01 000 000 000 0 0 0 0 0 0000000 0 012 000 0012000
sweep_s2   1 02 000 000 000 0 0 0 0 0 0000000 0 01e 005 001e005
sweep_s3   1 03 000 000 000 0 0 0 0 0 0000000 0 001 000 2001000
sweep_s4   1 04 000 000 000 0 0 0 0 0 0000000 0 000 f00 0000f00
sweep_s5   1 05 000 000 000 0 0 0 0 0 0000000 0 0a5 003 00a5003
sweep_s6   1 06 000 000 000 0 0 0 0 0 0000000 0 007 001 3007001
sweep_s7   1 07 000 000 000 0 0 0 0 0 0000000 0 007 001 3007001
sweep_s8   1 08 000 000 000 0 0 0 0 0 0000000 8 007 001 3007001
